/* common/lenet_pkg.sv */
package lenet_pkg;

    // window geometry
    localparam int num_taps  = 25;
    localparam int tap_idx_w = 5;
    localparam logic [tap_idx_w-1:0] last_tap = tap_idx_w'(num_taps - 1);

    // datapath widths
    localparam int data_w = 8;
    localparam int prod_w = 16;
    localparam int acc_w  = 21;   // 25 full-scale products
    localparam int bias_w = 16;
    localparam int sum_w  = acc_w + 1;  // acc plus bias, no wrap

    localparam int q_shift = 8;   // scale after bias

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        FINISH
    } ctrl_state_e;

    typedef struct packed {
        logic [data_w-1:0] pixel;
        logic [data_w-1:0] weight;
    } tap_pair_t;

    typedef struct packed {
        logic [acc_w-1:0]  acc;
        logic [data_w-1:0] act;
    } conv_result_t;

endpackage

/* hdl/conv_ctrl_fsm.sv */
`timescale 1ns/1ns

module conv_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last,
    output logic busy,
    output logic done,
    output logic cnt_clear,
    output logic cnt_step,
    output logic rd_en,
    output logic acc_clear,
    output logic acc_en,
    output logic finish
);

    lenet_pkg::ctrl_state_e state;
    lenet_pkg::ctrl_state_e state_nxt;

    logic kick;

    assign kick = (state == lenet_pkg::IDLE) && start;

    always_comb begin
        state_nxt = state;
        case (state)
            lenet_pkg::IDLE:   if (start) state_nxt = lenet_pkg::RUN;
            lenet_pkg::RUN:    if (last) state_nxt = lenet_pkg::DRAIN;  // final read issued
            lenet_pkg::DRAIN:  state_nxt = lenet_pkg::FINISH;
            lenet_pkg::FINISH: state_nxt = lenet_pkg::IDLE;
            default:           state_nxt = lenet_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lenet_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // accumulate trails the buffer read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_en <= 1'b0;
            done   <= 1'b0;
        end else begin
            acc_en <= rd_en;
            done   <= (state == lenet_pkg::FINISH);  // lines up with result
        end
    end

    assign busy      = (state != lenet_pkg::IDLE);
    assign rd_en     = (state == lenet_pkg::RUN);
    assign cnt_step  = rd_en;
    assign cnt_clear = kick;
    assign acc_clear = kick;
    assign finish    = (state == lenet_pkg::FINISH);

endmodule

/* hdl/lenet_conv_top.sv */
`timescale 1ns/1ns

module lenet_conv_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic [lenet_pkg::tap_idx_w-1:0] load_idx,
    input  lenet_pkg::tap_pair_t           load_pair,
    input  logic                           start,
    input  logic [lenet_pkg::bias_w-1:0]   bias,
    output logic                           busy,
    output logic                           done,
    output lenet_pkg::conv_result_t        result
);

    logic                            cnt_clear;
    logic                            cnt_step;
    logic                            rd_en;
    logic                            acc_clear;
    logic                            acc_en;
    logic                            finish;
    logic                            last;
    logic [lenet_pkg::tap_idx_w-1:0] idx;
    logic                            wr_en;
    lenet_pkg::tap_pair_t            rd_pair;
    logic [lenet_pkg::prod_w-1:0]    product;

    assign wr_en = load && !busy;  // window locked during a run

    conv_ctrl_fsm i_conv_ctrl_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .last      (last),
        .busy      (busy),
        .done      (done),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .rd_en     (rd_en),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .finish    (finish)
    );

    tap_counter i_tap_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (cnt_clear),
        .step  (cnt_step),
        .idx   (idx),
        .last  (last)
    );

    window_buffer i_window_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_idx  (load_idx),
        .wr_pair (load_pair),
        .rd_en   (rd_en),
        .rd_idx  (idx),
        .rd_pair (rd_pair)
    );

    approx_mult_8x8 i_approx_mult_8x8 (
        .x (rd_pair.pixel),
        .y (rd_pair.weight),
        .z (product)
    );

    mac_pipe i_mac_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (acc_clear),
        .acc_en  (acc_en),
        .finish  (finish),
        .product (product),
        .bias    (bias),
        .result  (result)
    );

endmodule

/* hdl/tap_counter.sv */
`timescale 1ns/1ns

module tap_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear,
    input  logic                           step,
    output logic [lenet_pkg::tap_idx_w-1:0] idx,
    output logic                           last
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step && !last) begin  // parks on the last tap
            idx <= idx + 1'b1;
        end
    end

    assign last = (idx == lenet_pkg::last_tap);

endmodule

/* hdl/window_buffer.sv */
`timescale 1ns/1ns

module window_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_en,
    input  logic [lenet_pkg::tap_idx_w-1:0] wr_idx,
    input  lenet_pkg::tap_pair_t           wr_pair,
    input  logic                           rd_en,
    input  logic [lenet_pkg::tap_idx_w-1:0] rd_idx,
    output lenet_pkg::tap_pair_t           rd_pair
);

    lenet_pkg::tap_pair_t mem [lenet_pkg::num_taps];

    // window cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lenet_pkg::num_taps; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en && (wr_idx <= lenet_pkg::last_tap)) begin
            mem[wr_idx] <= wr_pair;   // out of range index dropped
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pair <= '0;
        end else if (rd_en) begin
            rd_pair <= mem[rd_idx];
        end
    end

endmodule

/* mac/approx_mult_8x8.sv */
`timescale 1ns/1ns

module approx_mult_8x8 (
    input  logic [7:0]  x,
    input  logic [7:0]  y,
    output logic [15:0] z
);

    logic [7:0]  pp [8];     // AND rows, row i weighted by 2^i
    logic [12:0] term1;
    logic [12:0] term2;
    logic [12:0] term3;
    logic [12:0] term4;
    logic [12:0] term5;
    logic [12:0] term6;
    logic [15:0] upper;
    logic [15:0] lower;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    // compressed terms from rows 0 to 5, low columns dropped
    always_comb begin
        term1 = '0;
        term1[5]  = pp[2][2] ^ pp[3][1];
        term1[6]  = pp[2][3] ^ pp[3][2];
        term1[7]  = pp[4][2] & pp[5][1];
        term1[8]  = pp[0][7] ^ pp[1][6];
        term1[9]  = pp[2][7] ^ pp[3][6];
        term1[10] = pp[2][7] & pp[3][6];
        term1[11] = pp[4][7] & pp[5][6];
        term1[12] = pp[5][7];
    end

    always_comb begin
        term2 = '0;
        term2[6]  = pp[4][2] ^ pp[5][1];
        term2[8]  = pp[2][5] | pp[3][4];
        term2[9]  = pp[4][5] & pp[5][4];
        term2[10] = pp[3][7];
        term2[11] = pp[4][7] | pp[5][6];
    end

    always_comb begin
        term3 = '0;
        term3[8]  = pp[2][6] | pp[3][5];
        term3[9]  = pp[4][5] | pp[5][4];
        term3[10] = pp[4][6] & pp[5][5];
    end

    always_comb begin
        term4 = '0;
        term4[8]  = pp[4][3] | pp[5][2];
        term4[10] = pp[4][6] | pp[5][5];
    end

    // column 8 carry and sum of rows 4/5
    always_comb begin
        term5 = '0;
        term5[8] = pp[4][4] & pp[5][3];
    end

    always_comb begin
        term6 = '0;
        term6[8] = pp[4][4] ^ pp[5][3];
    end

    // rows 6 and 7 kept exact
    assign upper = {2'b00, pp[6], 6'b0} + {1'b0, pp[7], 7'b0};

    assign lower = {3'b000, term1} + {3'b000, term2} + {3'b000, term3}
                 + {3'b000, term4} + {3'b000, term5} + {3'b000, term6};

    assign z = upper + lower;

endmodule

/* mac/mac_pipe.sv */
`timescale 1ns/1ns

module mac_pipe (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        acc_en,
    input  logic                        finish,
    input  logic [lenet_pkg::prod_w-1:0] product,
    input  logic [lenet_pkg::bias_w-1:0] bias,
    output lenet_pkg::conv_result_t     result
);

    logic [lenet_pkg::acc_w-1:0]  acc;
    logic [lenet_pkg::bias_w-1:0] bias_q;
    logic [lenet_pkg::sum_w-1:0]  biased;
    logic [lenet_pkg::sum_w-1:0]  scaled;
    logic [lenet_pkg::data_w-1:0] act;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + {{(lenet_pkg::acc_w - lenet_pkg::prod_w){1'b0}}, product};
        end
    end

    // bias sampled with the start of a run
    always_ff @(posedge clk) begin
        if (clear) begin
            bias_q <= bias;
        end
    end

    assign biased = {1'b0, acc}
                  + {{(lenet_pkg::sum_w - lenet_pkg::bias_w){1'b0}}, bias_q};
    assign scaled = biased >> lenet_pkg::q_shift;

    // clip to 255
    always_comb begin
        if (|scaled[lenet_pkg::sum_w-1:lenet_pkg::data_w]) begin
            act = '1;
        end else begin
            act = scaled[lenet_pkg::data_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (finish) begin
            result.acc <= acc;
            result.act <= act;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_lenet_conv \
    -o sim_lenet_conv &&
./obj_dir/sim_lenet_conv | tee /dev/stderr | grep -q "^No errors$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* test/golden_conv.txt */
# record: name bias acc act (hex), then 25 tap words, pixel and weight as 4 hex digits
# taps run from index 0 to 24, acc and act are the expected result fields
all_zero 0000 000000 00
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
upper_rows 0040 0027C0 28
8005 8005 8005 8005 8005 8005 8005 8005 8005 8005 8005 8005 4003
4003 4003 4003 4003 4003 4003 4003 4003 4003 4003 4003 4003
full_scale FFFF 1831C0 FF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
saturate 0000 012C00 FF
C010 C010 C010 C010 C010 C010 C010 C010 C010 C010 C010 C010 C010
C010 C010 C010 C010 C010 C010 C010 C010 C010 C010 C010 C010
bias_shift 3A7F 000000 3A
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
mixed 0123 00D040 D1
3C5A 3C5A 3C5A 3C5A A5C3 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

/* test/tb_lenet_conv.sv */
`timescale 1ns/1ns

module tb_lenet_conv;

    localparam int max_tests = 16;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            load;
    logic [lenet_pkg::tap_idx_w-1:0] load_idx;
    lenet_pkg::tap_pair_t            load_pair;
    logic                            start;
    logic [lenet_pkg::bias_w-1:0]    bias;
    logic                            busy;
    logic                            done;
    lenet_pkg::conv_result_t         result;

    string                        names [max_tests];
    lenet_pkg::tap_pair_t         pairs [max_tests][lenet_pkg::num_taps];
    logic [lenet_pkg::bias_w-1:0] biases [max_tests];
    lenet_pkg::conv_result_t      expected [max_tests];
    int                           num_tests;
    lenet_pkg::conv_result_t      held_result;  // last result seen at done
    int                           cycle_count = 0;
    int                           cycle_limit = 100;
    int                           seed = 32'h125;

    lenet_conv_top i_lenet_conv_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .load_idx  (load_idx),
        .load_pair (load_pair),
        .start     (start),
        .bias      (bias),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    always #2 clk = ~clk;

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", test, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_result(input string test, input lenet_pkg::conv_result_t exp,
                                input lenet_pkg::conv_result_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s result: expected acc %h act %h, actual acc %h act %h",
                     test, exp.acc, exp.act, act.acc, act.act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string test, input string what, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test, what, exp, act);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: simulation ran past %0d cycles without finishing", cycle_limit);
            stop_on_error();
        end
    end

    task automatic read_golden();
        int          fd;
        int          code;
        int          i;
        bit          reading;
        string       tok;
        string       line;
        logic [31:0] b;
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] word;
        fd = $fopen("test/golden_conv.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file test/golden_conv.txt");
            stop_on_error();
        end
        num_tests = 0;
        reading = 1'b1;
        while (reading) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                reading = 1'b0;
            end else if (tok.substr(0, 0) == "#") begin
                code = $fgets(line, fd);  // rest of a comment line
            end else begin
                if (num_tests >= max_tests) begin
                    $display("golden file holds more than %0d records", max_tests);
                    stop_on_error();
                end
                names[num_tests] = tok;
                code = $fscanf(fd, " %h %h %h", b, a, c);
                if (code != 3) begin
                    $display("golden record %s has a malformed header line", tok);
                    stop_on_error();
                end
                biases[num_tests] = b[lenet_pkg::bias_w-1:0];
                expected[num_tests].acc = a[lenet_pkg::acc_w-1:0];
                expected[num_tests].act = c[lenet_pkg::data_w-1:0];
                for (i = 0; i < lenet_pkg::num_taps; i++) begin
                    code = $fscanf(fd, " %h", word);
                    if (code != 1) begin
                        $display("golden record %s is missing tap %0d", tok, i);
                        stop_on_error();
                    end
                    pairs[num_tests][i] = word[15:0];
                end
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("golden file holds no test records");
            stop_on_error();
        end
    endtask

    task automatic load_window(input int t);
        int i;
        for (i = 0; i < lenet_pkg::num_taps; i++) begin
            @(posedge clk);
            load      <= 1'b1;
            load_idx  <= lenet_pkg::tap_idx_w'(i);
            load_pair <= pairs[t][i];
            @(negedge clk);
            check_result({names[t], " hold"}, held_result, result);
        end
        @(posedge clk);
        load <= 1'b0;
    endtask

    // poke throws a load and a start at the DUT while it is busy
    task automatic run_window(input int t, input bit poke);
        int                              n;
        string                           name;
        lenet_pkg::tap_pair_t            poke_pair;
        logic [lenet_pkg::tap_idx_w-1:0] poke_idx;
        name = poke ? {names[t], "_poked"} : names[t];
        poke_pair = 16'($random(seed)) | 16'h8080;
        poke_idx = lenet_pkg::tap_idx_w'($unsigned($random(seed)) % lenet_pkg::num_taps);
        @(posedge clk);
        start <= 1'b1;
        bias  <= biases[t];
        @(posedge clk);  // edge 0
        start <= 1'b0;
        n = 0;
        @(negedge clk);
        check_flag(name, "busy", 1'b1, busy);
        check_flag(name, "done", 1'b0, done);
        while (!done && n < 40) begin
            @(posedge clk);
            n = n + 1;
            if (poke && n == 5) begin
                load      <= 1'b1;
                load_idx  <= poke_idx;
                load_pair <= poke_pair;
                start     <= 1'b1;
                bias      <= 16'hffff;
            end else begin
                load  <= 1'b0;
                start <= 1'b0;
            end
            @(negedge clk);
            if (!done) begin
                check_flag(name, "busy", 1'b1, busy);
                check_result({name, " hold"}, held_result, result);
            end
        end
        check_count(name, "edges from start to done", 27, n);
        check_flag(name, "busy after done", 1'b0, busy);
        check_result(name, expected[t], result);
        held_result = expected[t];
        @(posedge clk);
        @(negedge clk);
        check_flag(name, "done width", 1'b0, done);
        check_result({name, " hold"}, held_result, result);
    endtask

    initial begin
        int t;
        rst_n     = 1'b0;
        load      = 1'b0;
        load_idx  = '0;
        load_pair = '0;
        start     = 1'b0;
        bias      = '0;
        held_result = '0;
        read_golden();
        // loads plus run budget per test, two extra runs for the busy pokes
        cycle_limit = (num_tests + 2) * (lenet_pkg::num_taps + 40) + 100;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "done", 1'b0, done);
        check_result("reset", held_result, result);
        for (t = 0; t < num_tests; t++) begin
            load_window(t);
            run_window(t, 1'b0);
        end
        // last window stays loaded, rerun it with pokes and then clean
        run_window(num_tests - 1, 1'b1);
        run_window(num_tests - 1, 1'b0);
        $display("No errors");
        $finish;
    end

endmodule

/* verilog.f */
common/lenet_pkg.sv
mac/approx_mult_8x8.sv
mac/mac_pipe.sv
hdl/tap_counter.sv
hdl/conv_ctrl_fsm.sv
hdl/window_buffer.sv
hdl/lenet_conv_top.sv
test/tb_lenet_conv.sv
